// File: Makefile
# Verilator flow for the camera bring-up and DRAM write path

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= cam_dram_tb
RTL_TOP   ?= cam_dram_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) cam_bringup_pkg.sv bringup_sequencer.sv \
		write_port_select.sv cam_dram_top.sv --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST)) write_path_input.txt
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bringup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bringup_sequencer #(
    parameter int PWUP_CYCLES = 125000,
    parameter int INIT_CYCLES = 250000
) (
    input  wire  logic clk125M,
    input  wire  logic reset125M,
    input  wire  logic init_done_i,
    output logic       pwup_o,
    output logic       init_req_o,
    output logic       done_o
);

    // Room for the last compare value plus one step past it
    localparam int CNT_W = $clog2(INIT_CYCLES + 2);

    localparam logic [CNT_W-1:0] PWUP_LAST = CNT_W'(PWUP_CYCLES);
    localparam logic [CNT_W-1:0] INIT_LAST = CNT_W'(INIT_CYCLES);

    cam_bringup_pkg::seq_state_t state;
    logic [CNT_W-1:0]            cnt;
    logic                        cnt_run;

    // Counter only matters until the init request goes out
    assign cnt_run = (state == cam_bringup_pkg::WAIT_PWUP) ||
                     (state == cam_bringup_pkg::WAIT_INIT);

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            cnt <= '0;
        end else if (cnt_run) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            state      <= cam_bringup_pkg::WAIT_PWUP;
            pwup_o     <= 1'b0;
            init_req_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            // Request is a single pulse
            init_req_o <= 1'b0;

            case (state)
                cam_bringup_pkg::WAIT_PWUP: begin
                    if (cnt == PWUP_LAST) begin
                        pwup_o <= 1'b1;
                        state  <= cam_bringup_pkg::WAIT_INIT;
                    end
                end

                cam_bringup_pkg::WAIT_INIT: begin
                    if (cnt == INIT_LAST) begin
                        init_req_o <= 1'b1;
                        state      <= cam_bringup_pkg::WAIT_DONE;
                    end
                end

                // Sampled from the cycle after the request onward
                cam_bringup_pkg::WAIT_DONE: begin
                    if (init_done_i && !init_req_o) begin
                        done_o <= 1'b1;
                        state  <= cam_bringup_pkg::DONE;
                    end
                end

                default: begin
                    // Bring-up complete, hold until reset
                    state <= cam_bringup_pkg::DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: build.f
cam_bringup_pkg.sv
bringup_sequencer.sv
write_port_select.sv
cam_dram_top.sv
cam_dram_tb.sv

// File: cam_bringup_pkg.sv
`default_nettype none

package cam_bringup_pkg;

    // clk125M cycles in one millisecond
    localparam int CYCLES_PER_MS = 125000;

    // DRAM write port widths
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;
    localparam int ADDR_W = 32;

    // One word for the write data FIFO, strobes in the low bits
    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
    } wr_word_t;

    // One burst command, length above start address
    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } burst_ctrl_t;

    // Camera bring-up steps
    typedef enum logic [1:0] {
        WAIT_PWUP = 2'd0,
        WAIT_INIT = 2'd1,
        WAIT_DONE = 2'd2,
        DONE      = 2'd3
    } seq_state_t;

endpackage

`default_nettype wire

// File: cam_dram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cam_dram_tb;

    localparam int PWUP_CYCLES = 20;
    localparam int INIT_CYCLES = 40;

    // Vector file layout, twelve words per vector after the two header words
    localparam int FIELDS    = 12;
    localparam int MAX_VEC   = 64;
    localparam int MEM_DEPTH = 2 + FIELDS * MAX_VEC;

    // Random filler cycles between groups of vectors
    localparam int GAP_EVERY = 4;
    localparam int GAP_LEN   = 2;

    logic clk125M = 1'b0;
    logic reset125M;

    logic                         cam_init_done;
    logic                         cam_pwup;
    logic                         sccb_init_req;
    logic                         bringup_done;

    cam_bringup_pkg::wr_word_t    video_data;
    logic                         video_data_we;
    cam_bringup_pkg::wr_word_t    manual_data;
    logic                         manual_data_we;
    cam_bringup_pkg::wr_word_t    dram_data;
    logic                         dram_data_we;

    cam_bringup_pkg::burst_ctrl_t video_ctrl;
    logic                         video_ctrl_we;
    cam_bringup_pkg::burst_ctrl_t manual_ctrl;
    logic                         manual_ctrl_we;
    cam_bringup_pkg::burst_ctrl_t dram_ctrl;
    logic                         dram_ctrl_we;

    // Top bit marks an entry the file did not fill
    logic [40:0] vec_mem [0:MEM_DEPTH-1];

    int   seed = 53;
    int   value_errors = 0;
    int   other_errors = 0;
    int   init_delay;
    int   vec_count;
    logic loaded = 1'b0;

    // Expected write outputs for the current cycle
    cam_bringup_pkg::wr_word_t    exp_data;
    logic                         exp_data_we;
    cam_bringup_pkg::burst_ctrl_t exp_ctrl;
    logic                         exp_ctrl_we;

    cam_dram_top #(
        .PWUP_CYCLES      (PWUP_CYCLES),
        .INIT_CYCLES      (INIT_CYCLES)
    ) dut (
        .clk125M          (clk125M),
        .reset125M        (reset125M),
        .cam_init_done_i  (cam_init_done),
        .cam_pwup_o       (cam_pwup),
        .sccb_init_req_o  (sccb_init_req),
        .bringup_done_o   (bringup_done),
        .video_data_i     (video_data),
        .video_data_we_i  (video_data_we),
        .manual_data_i    (manual_data),
        .manual_data_we_i (manual_data_we),
        .dram_data_o      (dram_data),
        .dram_data_we_o   (dram_data_we),
        .video_ctrl_i     (video_ctrl),
        .video_ctrl_we_i  (video_ctrl_we),
        .manual_ctrl_i    (manual_ctrl),
        .manual_ctrl_we_i (manual_ctrl_we),
        .dram_ctrl_o      (dram_ctrl),
        .dram_ctrl_we_o   (dram_ctrl_we)
    );

    always #4 clk125M = ~clk125M;

    task automatic check_bit(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_write_outputs();
        check_bit(dram_data_we, exp_data_we, "dram_data_we_o");
        check_bit(dram_ctrl_we, exp_ctrl_we, "dram_ctrl_we_o");
        if (dram_data !== exp_data) begin
            $display("error at %0t ns: dram_data_o is %h, expected %h",
                     $time, dram_data, exp_data);
            value_errors++;
        end
        if (dram_ctrl !== exp_ctrl) begin
            $display("error at %0t ns: dram_ctrl_o is %h, expected %h",
                     $time, dram_ctrl, exp_ctrl);
            value_errors++;
        end
    endtask

    task automatic randomize_payloads();
        video_data  = 36'({$random(seed), $random(seed)});
        manual_data = 36'({$random(seed), $random(seed)});
        video_ctrl  = 40'({$random(seed), $random(seed)});
        manual_ctrl = 40'({$random(seed), $random(seed)});
    endtask

    // Check at the falling edge, then step to just after the next rising edge
    task automatic finish_cycle();
        @(negedge clk125M);
        check_write_outputs();
        @(posedge clk125M);
        #1;
    endtask

    task automatic load_vectors();
        int fd;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            vec_mem[i] = {1'b1, 40'h0};
        end
        fd = $fopen("write_path_input.txt", "r");
        if (fd == 0) begin
            $display("could not open write_path_input.txt");
            other_errors++;
            return;
        end
        $fclose(fd);
        $readmemh("write_path_input.txt", vec_mem);
        if (vec_mem[0][40] || vec_mem[1][40]) begin
            $display("vector file header is missing or unreadable");
            other_errors++;
            return;
        end
        init_delay = int'(vec_mem[0][39:0]);
        vec_count  = int'(vec_mem[1][39:0]);
        if (init_delay < 1 || vec_count < 1 || vec_count > MAX_VEC) begin
            $display("vector file header holds an unusable delay or vector count");
            other_errors++;
            return;
        end
        for (int i = 2; i < 2 + FIELDS * vec_count; i++) begin
            if (vec_mem[i][40]) begin
                $display("vector file ends early, fewer values than the header promises");
                other_errors++;
                return;
            end
        end
        loaded = 1'b1;
    endtask

    // Ends a run that stops making progress
    initial begin
        longint budget;
        wait (loaded);
        budget = INIT_CYCLES + init_delay + vec_count + GAP_LEN * (vec_count / GAP_EVERY) + 50;
        #(budget * 8);
        $display("timeout, the test did not finish in %0d cycles", budget);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int req_cycle;
        int base;

        reset125M      = 1'b1;
        cam_init_done  = 1'b0;
        video_data     = '0;
        video_data_we  = 1'b0;
        manual_data    = '0;
        manual_data_we = 1'b0;
        video_ctrl     = '0;
        video_ctrl_we  = 1'b0;
        manual_ctrl    = '0;
        manual_ctrl_we = 1'b0;
        exp_data       = '0;
        exp_data_we    = 1'b0;
        exp_ctrl       = '0;
        exp_ctrl_we    = 1'b0;

        load_vectors();

        if (loaded) begin
            repeat (2) @(posedge clk125M);
            #1;
            reset125M = 1'b0;

            // Bring-up sequence, cycle k starts here
            req_cycle = INIT_CYCLES + 1;
            for (int k = 0; k <= req_cycle + init_delay + 5; k++) begin
                // Stale init-done in the request cycle is not watched yet
                cam_init_done = (k == req_cycle) || (k >= req_cycle + init_delay);
                @(negedge clk125M);
                check_bit(cam_pwup, k > PWUP_CYCLES, "cam_pwup_o");
                check_bit(sccb_init_req, k == req_cycle, "sccb_init_req_o");
                check_bit(bringup_done, k > req_cycle + init_delay, "bringup_done_o");
                check_write_outputs();
                @(posedge clk125M);
                #1;
            end

            // Write path vectors
            for (int i = 0; i < vec_count; i++) begin
                if (i > 0 && i % GAP_EVERY == 0) begin
                    for (int g = 0; g < GAP_LEN; g++) begin
                        // Manual levels held, so no edge and no strobe
                        randomize_payloads();
                        video_data_we = 1'b0;
                        video_ctrl_we = 1'b0;
                        finish_cycle();
                        exp_data_we = 1'b0;
                        exp_ctrl_we = 1'b0;
                    end
                end
                base = 2 + FIELDS * i;
                video_data_we  = vec_mem[base][0];
                video_data     = vec_mem[base + 1][35:0];
                manual_data_we = vec_mem[base + 2][0];
                manual_data    = vec_mem[base + 3][35:0];
                video_ctrl_we  = vec_mem[base + 4][0];
                video_ctrl     = vec_mem[base + 5][39:0];
                manual_ctrl_we = vec_mem[base + 6][0];
                manual_ctrl    = vec_mem[base + 7][39:0];
                finish_cycle();
                exp_data_we = vec_mem[base + 8][0];
                exp_data    = vec_mem[base + 9][35:0];
                exp_ctrl_we = vec_mem[base + 10][0];
                exp_ctrl    = vec_mem[base + 11][39:0];
            end

            // Last vector's result
            video_data_we  = 1'b0;
            manual_data_we = 1'b0;
            video_ctrl_we  = 1'b0;
            manual_ctrl_we = 1'b0;
            finish_cycle();
        end

        $display("errors: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cam_dram_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_dram_top #(
    parameter int PWUP_CYCLES = cam_bringup_pkg::CYCLES_PER_MS,
    parameter int INIT_CYCLES = 2 * cam_bringup_pkg::CYCLES_PER_MS
) (
    input  wire  logic                        clk125M,
    input  wire  logic                        reset125M,

    // Camera bring-up
    input  wire  logic                        cam_init_done_i,
    output logic                              cam_pwup_o,
    output logic                              sccb_init_req_o,
    output logic                              bringup_done_o,

    // Write data channel
    input  wire  cam_bringup_pkg::wr_word_t   video_data_i,
    input  wire  logic                        video_data_we_i,
    input  wire  cam_bringup_pkg::wr_word_t   manual_data_i,
    input  wire  logic                        manual_data_we_i,
    output cam_bringup_pkg::wr_word_t         dram_data_o,
    output logic                              dram_data_we_o,

    // Burst control channel
    input  wire  cam_bringup_pkg::burst_ctrl_t video_ctrl_i,
    input  wire  logic                         video_ctrl_we_i,
    input  wire  cam_bringup_pkg::burst_ctrl_t manual_ctrl_i,
    input  wire  logic                         manual_ctrl_we_i,
    output cam_bringup_pkg::burst_ctrl_t       dram_ctrl_o,
    output logic                               dram_ctrl_we_o
);

    // Power-up and init request go to both cameras
    bringup_sequencer #(
        .PWUP_CYCLES (PWUP_CYCLES),
        .INIT_CYCLES (INIT_CYCLES)
    ) u_sequencer (
        .clk125M     (clk125M),
        .reset125M   (reset125M),
        .init_done_i (cam_init_done_i),
        .pwup_o      (cam_pwup_o),
        .init_req_o  (sccb_init_req_o),
        .done_o      (bringup_done_o)
    );

    // Data words into the AXI write engine
    write_port_select #(
        .payload_t   (cam_bringup_pkg::wr_word_t)
    ) u_data_sel (
        .clk125M     (clk125M),
        .reset125M   (reset125M),
        .video_i     (video_data_i),
        .video_we_i  (video_data_we_i),
        .manual_i    (manual_data_i),
        .manual_we_i (manual_data_we_i),
        .out_o       (dram_data_o),
        .out_we_o    (dram_data_we_o)
    );

    // Burst length and address
    write_port_select #(
        .payload_t   (cam_bringup_pkg::burst_ctrl_t)
    ) u_ctrl_sel (
        .clk125M     (clk125M),
        .reset125M   (reset125M),
        .video_i     (video_ctrl_i),
        .video_we_i  (video_ctrl_we_i),
        .manual_i    (manual_ctrl_i),
        .manual_we_i (manual_ctrl_we_i),
        .out_o       (dram_ctrl_o),
        .out_we_o    (dram_ctrl_we_o)
    );

endmodule

`default_nettype wire

// File: write_path_input.txt
// Header: init-done delay in cycles after the request, vector count (hex)
// Vectors: vd_we vd md_we md vc_we vc mc_we mc | exp d_we d, exp c_we c (next cycle)
05 16

// Video strobes, back to back on both channels
1 11111111f 0 000000000 0 0ff0000000 0 0000000000  1 11111111f 0 0000000000
1 22222222f 0 000000000 1 1000001000 0 0000000000  1 22222222f 1 1000001000
1 33333333c 0 000000000 1 2000002000 0 0000000000  1 33333333c 1 2000002000
0 44444444f 0 000000000 0 3000003000 0 0000000000  0 33333333c 0 2000002000

// Manual data rise, then held high
0 aaaaaaaa1 1 5555aaaa3 0 0000000000 0 0000000000  1 5555aaaa3 0 2000002000
0 bbbbbbbb2 1 66666666f 0 0000000000 0 0000000000  0 5555aaaa3 0 2000002000
1 77777777f 1 123123123 0 0000000000 1 40deadbeef  1 77777777f 1 40deadbeef
0 000000000 0 000000000 0 0000000000 1 4100000000  0 77777777f 0 40deadbeef

// Manual rise under a video strobe is lost
1 88888888f 1 99999999f 0 0000000000 0 0000000000  1 88888888f 0 40deadbeef
0 000000000 1 99999999f 1 8012345678 0 0000000000  0 88888888f 1 8012345678
0 000000000 0 000000000 1 9000000100 1 5500000000  0 88888888f 1 9000000100
0 000000000 1 abcdef013 0 0000000000 0 6600000000  1 abcdef013 0 9000000100

// Channels with different simultaneous traffic
0 000000000 0 000000000 0 0000000000 1 20cafe0000  0 abcdef013 1 20cafe0000
1 ccccdddd1 0 000000000 1 a0aaaa0000 1 7700000000  1 ccccdddd1 1 a0aaaa0000
1 eeeeffff8 1 123456787 0 0000000000 0 0000000000  1 eeeeffff8 0 a0aaaa0000
0 000000000 1 876543217 1 b0bbbb0000 0 0000000000  0 eeeeffff8 1 b0bbbb0000

// Manual rises on alternate channels
0 000000000 0 000000000 0 0000000000 1 c000001234  0 eeeeffff8 1 c000001234
0 000000000 1 0f0f0f0f5 0 0000000000 1 d000005678  1 0f0f0f0f5 0 c000001234
0 000000000 0 000000000 0 0000000000 0 0000000000  0 0f0f0f0f5 0 c000001234
1 fffffffff 0 000000000 1 ffffffffff 0 0000000000  1 fffffffff 1 ffffffffff

// All ones to small values, then idle
1 000000010 0 000000000 1 0000000001 0 0000000000  1 000000010 1 0000000001
0 000000000 0 000000000 0 0000000000 0 0000000000  0 000000010 0 0000000001

// File: write_port_select.sv
`timescale 1ns/1ps
`default_nettype none

module write_port_select #(
    parameter type payload_t = logic [31:0]
) (
    input  wire  logic     clk125M,
    input  wire  logic     reset125M,
    input  wire  payload_t video_i,
    input  wire  logic     video_we_i,
    input  wire  payload_t manual_i,
    input  wire  logic     manual_we_i,
    output payload_t       out_o,
    output logic           out_we_o
);

    logic manual_we_d;
    logic manual_rise;
    logic take;

    // Manual control is a level, one request per rising edge
    assign manual_rise = manual_we_i && !manual_we_d;

    // A manual edge under a video strobe is dropped
    assign take = video_we_i || manual_rise;

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            manual_we_d <= 1'b0;
        end else begin
            manual_we_d <= manual_we_i;
        end
    end

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            out_we_o <= 1'b0;
        end else begin
            out_we_o <= take;
        end
    end

    // Payload holds its last value between strobes
    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            out_o <= '0;
        end else if (take) begin
            if (video_we_i) begin
                out_o <= video_i;
            end else begin
                out_o <= manual_i;
            end
        end
    end

endmodule

`default_nettype wire
